// File: src/blast_scan_pkg.sv
// Query holds at most 256 bases. Bases are two-bit codes and the seed length is fixed at eight
`default_nettype none

package blast_scan_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Bus and stream words
  localparam int WORD_BITS      = 128;
  localparam int BASES_PER_WORD = 64;

  // Query capacity
  localparam int QUERY_BASES    = 256;
  localparam int QUERY_WORDS    = 4;

  // Seed and report shape
  localparam int SEED_BASES     = 8;
  localparam int HIT_WORDS      = 2;

  // Length register on the bus, every other address is query data
  localparam logic [31:0] LEN_ADDR = 32'h4000;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [1:0]                 base_t;
  typedef logic [WORD_BITS-1:0]       word_t;
  // Base i sits at bits 2i+1 down to 2i
  typedef logic [2*QUERY_BASES-1:0]   query_vec_t;
  typedef logic [QUERY_BASES-1:0]     pos_mask_t;
  // One bit per offset, the top seven offsets never hit
  typedef logic [QUERY_BASES-1:0]     hit_vec_t;
  // Holds 0 to 256
  typedef logic [$clog2(QUERY_BASES):0] query_len_t;
  typedef logic [31:0]                subject_len_t;
  typedef logic [31:0]                bus_addr_t;

  // Host write strobe with address and data
  typedef struct packed {
    logic      wr;
    bus_addr_t addr;
    word_t     data;
  } bus_wr_t;

  // Scan controller states
  typedef enum logic [2:0] {
    IDLE,
    SHIFT,
    CHECK,
    SEND,
    DONE
  } scan_state_t;

endpackage

`default_nettype wire

// File: src/query_store.sv
// Query words decode on address bits 5 to 4, and the query length must not exceed 256
`default_nettype none
`timescale 1ns/1ps

module query_store
  import blast_scan_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    rst,
  input  wire bus_wr_t bus,
  output query_vec_t   query,
  output pos_mask_t    query_mask,
  output subject_len_t subject_len,
  output logic         start
);

  // Write decode
  logic                           len_wr;
  logic                           query_wr;
  logic [$clog2(QUERY_WORDS)-1:0] widx;
  query_len_t                     query_len;

  assign len_wr   = bus.wr && (bus.addr == LEN_ADDR);
  assign query_wr = bus.wr && (bus.addr != LEN_ADDR);
  // Word index within the query
  assign widx     = bus.addr[5:4];

  //////////////////////////////
  // Query bases
  //////////////////////////////

  // Top two data bits give the lowest base of the word
  always_ff @(posedge clk)
  begin
    if (query_wr)
    begin
      for (int w = 0; w < QUERY_WORDS; w++)
      begin
        if (widx == w)
        begin
          for (int j = 0; j < BASES_PER_WORD; j++)
          begin
            query[2*(BASES_PER_WORD*w+j) +: 2] <= bus.data[WORD_BITS-1-2*j -: 2];
          end
        end
      end
    end
  end

  //////////////////////////////
  // Lengths and start
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      start       <= 1'b0;
      query_len   <= '0;
      subject_len <= '0;
    end
    else
    begin
      // Start follows the length write by one cycle
      start <= len_wr;
      if (len_wr)
      begin
        query_len   <= bus.data[40:32];
        subject_len <= bus.data[31:0];
      end
    end
  end

  // Positions below the query length are valid
  always_comb
  begin
    for (int i = 0; i < QUERY_BASES; i++)
    begin
      query_mask[i] = (query_len_t'(i) < query_len);
    end
  end

endmodule

`default_nettype wire

// File: src/subject_shifter.sv
// One subject word is buffered at a time, and intake stays closed until the first start
`default_nettype none
`timescale 1ns/1ps

module subject_shifter
  import blast_scan_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  start,
  input  wire logic  step,
  input  wire logic  in_valid,
  input  wire word_t in_data,
  output logic       in_rdy,
  output logic       base_ready,
  output query_vec_t window,
  output pos_mask_t  fill_mask,
  output subject_len_t position
);

  // Held word and count of unused bases in it
  word_t                           word_buf;
  logic [$clog2(BASES_PER_WORD):0] left;
  // Set by the first start
  logic                            armed;
  logic                            take;

  // New word only once the held one is used up
  assign in_rdy     = armed && (left == '0) && !start;
  assign take       = in_valid && in_rdy;
  assign base_ready = (left != '0);

  //////////////////////////////
  // Control and bookkeeping
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      armed     <= 1'b0;
      left      <= '0;
      fill_mask <= '0;
      position  <= '0;
    end
    else if (start)
    begin
      armed     <= 1'b1;
      left      <= '0;
      fill_mask <= '0;
      position  <= '0;
    end
    else if (take)
    begin
      left <= BASES_PER_WORD[$clog2(BASES_PER_WORD):0];
    end
    else if (step)
    begin
      left      <= left - 1'b1;
      // Newest position is always filled
      fill_mask <= {fill_mask[QUERY_BASES-2:0], 1'b1};
      position  <= position + 1'b1;
    end
  end

  //////////////////////////////
  // Data path
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      window <= '0;
    end
    else if (take)
    begin
      word_buf <= in_data;
    end
    else if (step)
    begin
      // Window moves up, next base enters at position 0
      window   <= {window[2*QUERY_BASES-3:0], word_buf[WORD_BITS-1 -: 2]};
      word_buf <= word_buf << 2;
    end
  end

endmodule

`default_nettype wire

// File: src/seed_matcher.sv
// Results appear two cycles after a step, since the window itself settles one cycle after it
`default_nettype none
`timescale 1ns/1ps

module seed_matcher
  import blast_scan_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       step,
  input  wire query_vec_t window,
  input  wire query_vec_t query,
  input  wire pos_mask_t  fill_mask,
  input  wire pos_mask_t  query_mask,
  output hit_vec_t        hit_vec,
  output logic            hit_any
);

  // Per-position match and per-offset seed result
  pos_mask_t eq;
  hit_vec_t  hits;
  // Window holds the stepped base one cycle after step
  logic      step_q;

  always_comb
  begin
    for (int i = 0; i < QUERY_BASES; i++)
    begin
      eq[i] = (window[2*i +: 2] == query[2*i +: 2]) && fill_mask[i] && query_mask[i];
    end
    hits = '0;
    // Offsets whose seed runs past the end stay 0
    for (int k = 0; k <= QUERY_BASES - SEED_BASES; k++)
    begin
      hits[k] = &eq[k +: SEED_BASES];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      step_q  <= 1'b0;
      hit_any <= 1'b0;
    end
    else
    begin
      step_q  <= step;
      hit_any <= step_q && (|hits);
    end
  end

  // Bitmap payload
  always_ff @(posedge clk)
  begin
    if (step_q)
    begin
      hit_vec <= hits;
    end
  end

endmodule

`default_nettype wire

// File: src/scan_ctrl.sv
// A new start is only honoured in IDLE or DONE, and each base takes three cycles without a hit
`default_nettype none
`timescale 1ns/1ps

module scan_ctrl
  import blast_scan_pkg::*;
(
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire logic         start,
  input  wire logic         base_ready,
  input  wire subject_len_t position,
  input  wire subject_len_t subject_len,
  input  wire logic         hit_any,
  input  wire logic         sent,
  output logic              step,
  output logic              send,
  output logic              scan_done
);

  scan_state_t state;
  // First CHECK cycle waits for the matcher result
  logic        settle;
  logic        at_end;

  assign at_end = (position == subject_len);

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state  <= IDLE;
      settle <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE, DONE:
        begin
          if (start)
          begin
            state <= SHIFT;
          end
        end
        SHIFT:
        begin
          // Covers zero length and the end after a report
          if (at_end)
          begin
            state <= DONE;
          end
          else if (base_ready)
          begin
            state  <= CHECK;
            settle <= 1'b1;
          end
        end
        CHECK:
        begin
          if (settle)
          begin
            settle <= 1'b0;
          end
          else if (hit_any)
          begin
            state <= SEND;
          end
          else if (at_end)
          begin
            state <= DONE;
          end
          else
          begin
            state <= SHIFT;
          end
        end
        SEND:
        begin
          // Shifting stalls until the report drains
          if (sent)
          begin
            state <= SHIFT;
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // One base per SHIFT visit
  assign step      = (state == SHIFT) && base_ready && !at_end;
  assign send      = (state == CHECK) && !settle && hit_any;
  assign scan_done = (state == DONE);

endmodule

`default_nettype wire

// File: src/report_sender.sv
// A send arriving while a report is still in flight is ignored
`default_nettype none
`timescale 1ns/1ps

module report_sender
  import blast_scan_pkg::*;
(
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire logic         send,
  input  wire subject_len_t position,
  input  wire hit_vec_t     hit_vec,
  output logic              out_valid,
  input  wire logic         out_rdy,
  output word_t             out_data,
  output logic              sent
);

  // Beat 0 is the position, then the bitmap words low first
  logic [1:0]   beat;
  logic         last_beat;
  logic         load;
  subject_len_t pos_q;
  hit_vec_t     hits_q;

  assign load      = send && !out_valid;
  assign last_beat = (beat == 2'(HIT_WORDS));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      out_valid <= 1'b0;
      beat      <= '0;
      sent      <= 1'b0;
    end
    else
    begin
      sent <= 1'b0;
      if (load)
      begin
        out_valid <= 1'b1;
        beat      <= '0;
      end
      else if (out_valid && out_rdy)
      begin
        if (last_beat)
        begin
          out_valid <= 1'b0;
          sent      <= 1'b1;
        end
        else
        begin
          beat <= beat + 1'b1;
        end
      end
    end
  end

  // Report payload
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      pos_q  <= position;
      hits_q <= hit_vec;
    end
  end

  // Beat select, steady while the sink stalls
  always_comb
  begin
    case (beat)
      2'd0:    out_data = word_t'(pos_q);
      2'd1:    out_data = hits_q[WORD_BITS-1:0];
      default: out_data = hits_q[2*WORD_BITS-1:WORD_BITS];
    endcase
  end

endmodule

`default_nettype wire

// File: src/blast_scan_top.sv
// Load the query before the length write, and one report stalls the whole scan until it drains
`default_nettype none
`timescale 1ns/1ps

module blast_scan_top
  import blast_scan_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    rst,
  // Host write bus
  input  wire bus_wr_t bus,
  // Subject stream
  input  wire logic    in_valid,
  output logic         in_rdy,
  input  wire word_t   in_data,
  // Report stream
  output logic         out_valid,
  input  wire logic    out_rdy,
  output word_t        out_data,
  // Scan finished
  output logic         scan_done
);

  //////////////////////////////
  // Internal nets
  //////////////////////////////

  // Query side
  query_vec_t   query;
  pos_mask_t    query_mask;
  subject_len_t subject_len;
  logic         start;

  // Subject window
  logic         step;
  logic         base_ready;
  query_vec_t   window;
  pos_mask_t    fill_mask;
  subject_len_t position;

  // Match results and report handshake
  hit_vec_t     hit_vec;
  logic         hit_any;
  logic         send;
  logic         sent;

  //////////////////////////////
  // Blocks
  //////////////////////////////

  // Bus decode and query storage
  query_store u_query_store (
    .clk         (clk),
    .rst         (rst),
    .bus         (bus),
    .query       (query),
    .query_mask  (query_mask),
    .subject_len (subject_len),
    .start       (start)
  );

  // Subject intake and base window
  subject_shifter u_subject_shifter (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .step       (step),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_rdy     (in_rdy),
    .base_ready (base_ready),
    .window     (window),
    .fill_mask  (fill_mask),
    .position   (position)
  );

  // Diagonal seed compare
  seed_matcher u_seed_matcher (
    .clk        (clk),
    .rst        (rst),
    .step       (step),
    .window     (window),
    .query      (query),
    .fill_mask  (fill_mask),
    .query_mask (query_mask),
    .hit_vec    (hit_vec),
    .hit_any    (hit_any)
  );

  // Scan sequencing
  scan_ctrl u_scan_ctrl (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .base_ready  (base_ready),
    .position    (position),
    .subject_len (subject_len),
    .hit_any     (hit_any),
    .sent        (sent),
    .step        (step),
    .send        (send),
    .scan_done   (scan_done)
  );

  // Three-beat report output
  report_sender u_report_sender (
    .clk       (clk),
    .rst       (rst),
    .send      (send),
    .position  (position),
    .hit_vec   (hit_vec),
    .out_valid (out_valid),
    .out_rdy   (out_rdy),
    .out_data  (out_data),
    .sent      (sent)
  );

endmodule

`default_nettype wire

// File: test/blast_scan_assertions.sv
// Bound to blast_scan_top; covers report stream stability, reset state and done/report exclusion only
`default_nettype none
`timescale 1ns/1ps

module blast_scan_assertions
  import blast_scan_pkg::*;
(
  input wire logic  clk,
  input wire logic  rst,
  input wire logic  in_rdy,
  input wire logic  out_valid,
  input wire logic  out_rdy,
  input wire word_t out_data,
  input wire logic  scan_done
);

  //////////////////////////////
  // Report stream
  //////////////////////////////

  // A stalled beat keeps its data
  out_data_stable: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_rdy) |=> $stable(out_data)
  ) else $error("out_data changed while the sink stalled");

  // Intake and reports are closed right after a reset cycle
  reset_quiet: assert property (
    @(posedge clk)
    rst |=> (!in_rdy && !out_valid)
  ) else $error("in_rdy or out_valid high after reset");

  // Done only once the last report has drained
  done_not_sending: assert property (
    @(posedge clk) disable iff (rst)
    !(scan_done && out_valid)
  ) else $error("scan_done and out_valid high together");

endmodule

bind blast_scan_top blast_scan_assertions u_assertions (.*);

`default_nettype wire

// File: test/blast_scan_tb.sv
// Each test feeds at most eight subject words, so subject lengths above 512 bases would stall
`default_nettype none
`timescale 1ns/1ps

module blast_scan_tb;
  import blast_scan_pkg::*;

  localparam int N_TESTS    = 8;
  localparam int SUBJ_WORDS = 8;
  localparam int SUBJ_BASES = SUBJ_WORDS * BASES_PER_WORD;

  // Word patterns used by the table
  localparam word_t ZERO  = '0;
  localparam word_t ONES  = {WORD_BITS{1'b1}};
  // Query seed 1,2,2,1,2,1,1,2 at bases 68 to 75
  localparam word_t QSEED = 128'h0069_9600_0000_0000_0000_0000_0000_0000;
  // Same seed reversed at subject bases 40 to 47 on a background of base 3
  localparam word_t SSEED = 128'hFFFF_FFFF_FFFF_FFFF_FFFF_9669_FFFF_FFFF;

  // DUT ports
  logic    clk;
  logic    rst;
  bus_wr_t bus;
  logic    in_valid;
  logic    in_rdy;
  word_t   in_data;
  logic    out_valid;
  logic    out_rdy;
  word_t   out_data;
  logic    scan_done;

  // Test table
  string        t_name    [N_TESTS];
  word_t        t_query   [N_TESTS][QUERY_WORDS];
  query_len_t   t_qlen    [N_TESTS];
  word_t        t_subj    [N_TESTS][SUBJ_WORDS];
  subject_len_t t_slen    [N_TESTS];
  bit           t_rnd_rdy [N_TESTS];
  int           t_reports [N_TESTS];
  int           n_tests;

  // Run state
  string cur_name;
  word_t exp_beats[$];
  word_t act_beats[$];
  int    exp_reports;
  int    cycles;
  int    cycle_limit;
  integer seed;

  blast_scan_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .bus       (bus),
    .in_valid  (in_valid),
    .in_rdy    (in_rdy),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_rdy   (out_rdy),
    .out_data  (out_data),
    .scan_done (scan_done)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Timeout
  //////////////////////////////

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("Timeout: the scans did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Compare and stop at the first mismatch
  task automatic check_value(input string what, input logic [WORD_BITS-1:0] expected,
                             input logic [WORD_BITS-1:0] actual);
    if (actual !== expected)
    begin
      $display("ERR %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
      $display("Simulation failed");
      $fatal(1, "check mismatch");
    end
  endtask

  // One table row with subject words 1 to 7 sharing one pattern
  task automatic add_entry(input string name, input word_t q0, input word_t q1,
                           input word_t q2, input word_t q3, input query_len_t qlen,
                           input word_t s0, input word_t s_rest, input subject_len_t slen,
                           input bit rnd_rdy, input int reports);
    t_name[n_tests]     = name;
    t_query[n_tests][0] = q0;
    t_query[n_tests][1] = q1;
    t_query[n_tests][2] = q2;
    t_query[n_tests][3] = q3;
    t_qlen[n_tests]     = qlen;
    t_subj[n_tests][0]  = s0;
    for (int w = 1; w < SUBJ_WORDS; w++)
    begin
      t_subj[n_tests][w] = s_rest;
    end
    t_slen[n_tests]     = slen;
    t_rnd_rdy[n_tests]  = rnd_rdy;
    t_reports[n_tests]  = reports;
    n_tests             = n_tests + 1;
  endtask

  task automatic load_table;
    n_tests = 0;
    // Nothing in common between query and subject
    add_entry("no_hits", ZERO, ZERO, ZERO, ZERO, 9'd256, ONES, ONES, 300, 1'b0, 0);
    // One diagonal at offset 68 reported at position 116
    add_entry("single_seed", ZERO, QSEED, ZERO, ZERO, 9'd256, SSEED, ONES, 200, 1'b0, 1);
    // Seed ends at base 75, so 76 keeps it and 75 drops it
    add_entry("qlen_keep", ZERO, QSEED, ZERO, ZERO, 9'd76, SSEED, ONES, 200, 1'b0, 1);
    add_entry("qlen_cut", ZERO, QSEED, ZERO, ZERO, 9'd75, SSEED, ONES, 200, 1'b0, 0);
    // All zero on both sides gives one report per step from 8 on
    add_entry("flood_ready", ZERO, ZERO, ZERO, ZERO, 9'd256, ZERO, ZERO, 280, 1'b0, 273);
    add_entry("flood_random", ZERO, ZERO, ZERO, ZERO, 9'd256, ZERO, ZERO, 280, 1'b1, 273);
    // Re-arm straight after the flood with a zero window left behind
    add_entry("rearm_no_hits", ZERO, ZERO, ZERO, ZERO, 9'd256, ONES, ONES, 300, 1'b0, 0);
    // Length ends right on the seed while more data is offered than used
    add_entry("short_len", ZERO, QSEED, ZERO, ZERO, 9'd256, SSEED, ONES, 116, 1'b1, 1);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Step n puts subject base n-1-p at window position p
  task automatic build_expected(input int t);
    base_t    qb [QUERY_BASES];
    base_t    sb [SUBJ_BASES];
    hit_vec_t hv;
    bit       seed_ok;
    exp_beats.delete();
    exp_reports = 0;
    for (int i = 0; i < QUERY_BASES; i++)
    begin
      qb[i] = t_query[t][i / BASES_PER_WORD][WORD_BITS-1-2*(i % BASES_PER_WORD) -: 2];
    end
    for (int j = 0; j < SUBJ_BASES; j++)
    begin
      sb[j] = t_subj[t][j / BASES_PER_WORD][WORD_BITS-1-2*(j % BASES_PER_WORD) -: 2];
    end
    for (int n = 1; n <= int'(t_slen[t]); n++)
    begin
      hv = '0;
      for (int k = 0; k <= QUERY_BASES - SEED_BASES; k++)
      begin
        seed_ok = 1'b1;
        for (int i = k; i < k + SEED_BASES; i++)
        begin
          // Unfilled or beyond the query length never matches
          if (i >= n || i >= int'(t_qlen[t]))
          begin
            seed_ok = 1'b0;
          end
          else if (sb[n-1-i] != qb[i])
          begin
            seed_ok = 1'b0;
          end
        end
        hv[k] = seed_ok;
      end
      if (hv != '0)
      begin
        exp_beats.push_back(word_t'(n));
        exp_beats.push_back(hv[WORD_BITS-1:0]);
        exp_beats.push_back(hv[2*WORD_BITS-1:WORD_BITS]);
        exp_reports = exp_reports + 1;
      end
    end
  endtask

  //////////////////////////////
  // One test
  //////////////////////////////

  task automatic run_test(input int t);
    int          idx;
    bit          busy_seen;
    bit          finished;
    logic [31:0] r;
    word_t       last_pos;
    cur_name = t_name[t];
    build_expected(t);
    check_value("model report count", t_reports[t], exp_reports);
    act_beats.delete();
    // Query first, then the length write that arms the scan
    for (int w = 0; w < QUERY_WORDS; w++)
    begin
      @(posedge clk);
      in_valid <= 1'b0;
      out_rdy  <= 1'b1;
      bus      <= {1'b1, bus_addr_t'(w * 16), t_query[t][w]};
    end
    @(posedge clk);
    bus <= {1'b1, LEN_ADDR, {87'd0, t_qlen[t], t_slen[t]}};
    @(posedge clk);
    bus <= '0;
    idx       = 0;
    busy_seen = 1'b0;
    finished  = 1'b0;
    // Stale scan_done from the last test is ignored until the scan runs
    while (!finished)
    begin
      @(posedge clk);
      if (out_valid && out_rdy)
      begin
        act_beats.push_back(out_data);
      end
      if (in_valid && in_rdy)
      begin
        idx = idx + 1;
      end
      if (!scan_done)
      begin
        busy_seen = 1'b1;
      end
      else if (busy_seen)
      begin
        finished = 1'b1;
      end
      in_valid <= (idx < SUBJ_WORDS);
      in_data  <= t_subj[t][(idx < SUBJ_WORDS) ? idx : 0];
      r = $random(seed);
      out_rdy  <= t_rnd_rdy[t] ? r[0] : 1'b1;
    end
    // A partly used word keeps intake closed once the scan stops
    repeat (8)
    begin
      @(posedge clk);
      check_value("out_valid after done", 1'b0, out_valid);
      check_value("scan_done held", 1'b1, scan_done);
      if (t_slen[t] % BASES_PER_WORD != 0)
      begin
        check_value("in_rdy after done", 1'b0, in_rdy);
      end
    end
    check_value("beat count", exp_beats.size(), act_beats.size());
    check_value("report count", 3 * t_reports[t], act_beats.size());
    for (int i = 0; i < act_beats.size(); i++)
    begin
      check_value($sformatf("beat %0d", i), exp_beats[i], act_beats[i]);
    end
    if (act_beats.size() >= 3)
    begin
      last_pos = act_beats[act_beats.size() - 3];
      check_value("final position within length", 1'b1, last_pos <= word_t'(t_slen[t]));
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    rst      = 1'b1;
    bus      = '0;
    in_valid = 1'b0;
    in_data  = '0;
    out_rdy  = 1'b0;
    seed     = 32'h74a8_f573;
    cycles   = 0;
    cur_name = "reset";
    load_table;
    cycle_limit = 0;
    for (int t = 0; t < n_tests; t++)
    begin
      cycle_limit = cycle_limit + int'(t_slen[t]) * 5 + 50;
    end
    cycle_limit = cycle_limit * 4;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    // Everything idle until the first length write
    check_value("in_rdy", 1'b0, in_rdy);
    check_value("out_valid", 1'b0, out_valid);
    check_value("scan_done", 1'b0, scan_done);
    for (int t = 0; t < n_tests; t++)
    begin
      run_test(t);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
src/blast_scan_pkg.sv
src/query_store.sv
src/subject_shifter.sv
src/seed_matcher.sv
src/scan_ctrl.sv
src/report_sender.sv
src/blast_scan_top.sv
test/blast_scan_assertions.sv
test/blast_scan_tb.sv
